// ==== verilog/kmcMicroPkg.sv ====
////////////////////////////////////////
// KMC microword format
// Field types, field positions and the source,
// destination and ALU function codes
////////////////////////////////////////

`default_nettype none

package kmcMicroPkg;

   // Whole microword
   typedef logic [15:0] microWord;

   // Field types
   typedef logic [2:0] srcSel;
   typedef logic [2:0] dstSel;
   typedef logic [3:0] aluFun;

   // Field positions
   // Bits 9 and 8 are reserved
   localparam int srcMsb    = 15;
   localparam int srcLsb    = 13;
   localparam int dstMsb    = 12;
   localparam int dstLsb    = 10;
   localparam int funMsb    = 7;
   localparam int funLsb    = 4;
   localparam int spAddrMsb = 3;
   localparam int spAddrLsb = 0;
   // Immediate byte overlays FUN and SPADDR
   localparam int immMsb    = 7;
   localparam int immLsb    = 0;

   ////////////////////////////////////////
   // Source codes
   // Bit 14 clear means the ALU passes B
   localparam srcSel movImmed = 3'd0;
   localparam srcSel movIbus  = 3'd1;
   localparam srcSel movMem   = 3'd2;
   localparam srcSel movBrg   = 3'd3;
   localparam srcSel jmpImmed = 3'd4;
   localparam srcSel movIbuss = 3'd5;
   localparam srcSel jmpCond  = 3'd6;
   localparam srcSel nop      = 3'd7;

   ////////////////////////////////////////
   // Destination codes
   localparam dstSel dstNone  = 3'd0;
   localparam dstSel dstObus  = 3'd1;
   localparam dstSel dstObuss = 3'd2;
   localparam dstSel dstSp    = 3'd4;
   localparam dstSel dstSpBrg = 3'd5;
   localparam dstSel dstBrg   = 3'd6;

   ////////////////////////////////////////
   // ALU function codes, A from scratch pad, B from the data mux
   localparam aluFun funAdd    = 4'd0;   // A + B
   localparam aluFun funAddC   = 4'd1;   // A + B + C
   localparam aluFun funSubC   = 4'd2;   // A - B - C
   localparam aluFun funIncA   = 4'd3;   // A + 1
   localparam aluFun funAPlusC = 4'd4;   // A + C
   localparam aluFun funTwoA   = 4'd5;   // A + A
   localparam aluFun funTwoAC  = 4'd6;   // A + A + C
   localparam aluFun funDecA   = 4'd7;   // A - 1
   localparam aluFun funSelA   = 4'd8;   // A
   localparam aluFun funSelB   = 4'd9;   // B
   localparam aluFun funAOrNB  = 4'd10;  // A | ~B
   localparam aluFun funAAndB  = 4'd11;  // A & B
   localparam aluFun funAOrB   = 4'd12;  // A | B
   localparam aluFun funAXorB  = 4'd13;  // A ^ B
   localparam aluFun funSub    = 4'd14;  // A - B
   localparam aluFun funSubOC  = 4'd15;  // A - B - 1

   // Move instructions, the only ones that write
   function automatic logic isMove(srcSel src);
      return (src == movImmed) || (src == movIbus) || (src == movMem) ||
             (src == movBrg)   || (src == movIbuss);
   endfunction

endpackage

`default_nettype wire

// ==== verilog/kmcDataPkg.sv ====
////////////////////////////////////////
// KMC data path types
// Byte and scratch pad address types, sequencer states
////////////////////////////////////////

`default_nettype none

package kmcDataPkg;

   // Every data port carries one byte
   typedef logic [7:0] dataByte;

   // Sixteen scratch pad locations
   typedef logic [3:0] spIndex;

   // Two-phase microinstruction sequencer
   typedef enum logic [1:0]
   {
      seqIdle,
      seqRead,
      seqExec
   } seqState;

endpackage

`default_nettype wire

// ==== verilog/kmcSequencer.sv ====
////////////////////////////////////////
// KMC microinstruction sequencer
// Spreads each step over a read and an execute phase
////////////////////////////////////////

`default_nettype none

module kmcSequencer
(
   input  logic clk,
   input  logic rst,
   input  logic step,
   output logic spClkEn,
   output logic aluClkEn,
   output logic writeEn,
   output logic done
);
   import kmcDataPkg::*;

   seqState state;
   seqState nextState;
   logic    execPhase;

   // Next state
   // Step only counts in idle
   always_comb
   begin
      case (state)
         seqIdle:
            nextState = step ? seqRead : seqIdle;
         seqRead:
            nextState = seqExec;
         seqExec:
            nextState = seqIdle;
         default:
            nextState = seqIdle;
      endcase
   end

   // State register and done pulse
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= seqIdle;
         done  <= 1'b0;
      end
      else
      begin
         state <= nextState;
         // Results land at the end of exec
         done  <= execPhase;
      end
   end

   // All enables open for the execute cycle only
   assign execPhase = (state == seqExec);
   assign spClkEn   = execPhase;
   assign aluClkEn  = execPhase;
   assign writeEn   = execPhase;

endmodule

`default_nettype wire

// ==== verilog/kmcDataMux.sv ====
////////////////////////////////////////
// KMC data mux
// Picks the ALU B operand from the source field
////////////////////////////////////////

`default_nettype none

module kmcDataMux
(
   input  kmcMicroPkg::microWord cram,
   input  kmcDataPkg::dataByte   ibus,
   input  kmcDataPkg::dataByte   ibuss,
   input  kmcDataPkg::dataByte   memData,
   input  kmcDataPkg::dataByte   brg,
   output kmcDataPkg::dataByte   dmux
);
   import kmcMicroPkg::*;

   srcSel src;

   // Source field decode
   assign src = cram[srcMsb:srcLsb];

   always_comb
   begin
      case (src)
         // Immediate byte for both move and jump
         movImmed,
         jmpImmed:
            dmux = cram[immMsb:immLsb];
         movIbus:
            dmux = ibus;
         movIbuss:
            dmux = ibuss;
         movMem:
            dmux = memData;
         movBrg:
            dmux = brg;
         // Conditional jump and nop feed nothing
         default:
            dmux = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/kmcAlu.sv ====
////////////////////////////////////////
// KMC arithmetic unit
// Sixteen-byte scratch pad, function decode,
// 8-bit ALU, carry and all-ones flags
////////////////////////////////////////

`default_nettype none

module kmcAlu
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  init,
   input  logic                  spClkEn,
   input  logic                  aluClkEn,
   input  kmcMicroPkg::microWord cram,
   input  kmcDataPkg::dataByte   dmux,
   output kmcDataPkg::dataByte   aluResult,
   output logic                  aluC,
   output logic                  aluOnes
);
   import kmcMicroPkg::*;
   import kmcDataPkg::*;

   srcSel      src;
   dstSel      dst;
   aluFun      fun;
   logic       srcMove;
   logic       dstSpad;
   logic       dstOut;
   logic       spWrite;
   logic       srcCarry;
   logic       funCarry;
   logic       passB;
   spIndex     spAddr;
   spIndex     rdAddr;
   dataByte    spad [0:15];
   dataByte    aluA;
   dataByte    aluB;
   logic [8:0] wide;

   ////////////////////////////////////////
   // Microword decode

   assign src = cram[srcMsb:srcLsb];
   assign dst = cram[dstMsb:dstLsb];
   assign fun = cram[funMsb:funLsb];

   assign srcMove = isMove(src);
   assign dstSpad = (dst == dstSp) || (dst == dstSpBrg);
   assign dstOut  = (dst == dstObus) || (dst == dstObuss);
   assign spWrite = srcMove && dstSpad;

   // Only memory and brg sources touch the carry
   assign srcCarry = (src == movMem) || (src == movBrg);

   // Arithmetic functions, logic and selects excluded
   assign funCarry = !(fun inside {funSelA, funSelB, funAOrNB,
                                   funAAndB, funAOrB, funAXorB});

   // Sources that bypass the function table
   assign passB = (src == movImmed) || (src == jmpImmed) ||
                  (src == movIbus)  || (src == movIbuss);

   ////////////////////////////////////////
   // Scratch pad

   // Output bus moves always use location 0
   assign spAddr = dstOut ? spIndex'(0) : cram[spAddrMsb:spAddrLsb];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 16; i++)
            spad[i] <= '0;
         rdAddr <= '0;
      end
      else
      begin
         if (spWrite && spClkEn)
            spad[spAddr] <= aluResult;
         // Read address lags one cycle
         rdAddr <= spAddr;
      end
   end

   // Operands
   assign aluA = spad[rdAddr];
   assign aluB = dmux;

   ////////////////////////////////////////
   // Function table
   // Bit 8 is carry out for sums, borrow for differences

   always_comb
   begin
      wide = {1'b0, aluB};
      if (!passB)
      begin
         case (fun)
            funAdd:    wide = {1'b0, aluA} + {1'b0, aluB};
            funAddC:   wide = {1'b0, aluA} + {1'b0, aluB} + {8'd0, aluC};
            funSubC:   wide = {1'b0, aluA} - {1'b0, aluB} - {8'd0, aluC};
            funIncA:   wide = {1'b0, aluA} + 9'd1;
            funAPlusC: wide = {1'b0, aluA} + {8'd0, aluC};
            funTwoA:   wide = {1'b0, aluA} + {1'b0, aluA};
            funTwoAC:  wide = {1'b0, aluA} + {1'b0, aluA} + {8'd0, aluC};
            funDecA:   wide = {1'b0, aluA} - 9'd1;
            // Carry 0 from here to funAXorB
            funSelA:   wide = {1'b0, aluA};
            funSelB:   wide = {1'b0, aluB};
            funAOrNB:  wide = {1'b0, aluA | ~aluB};
            funAAndB:  wide = {1'b0, aluA & aluB};
            funAOrB:   wide = {1'b0, aluA | aluB};
            funAXorB:  wide = {1'b0, aluA ^ aluB};
            funSub:    wide = {1'b0, aluA} - {1'b0, aluB};
            funSubOC:  wide = {1'b0, aluA} - {1'b0, aluB} - 9'd1;
            default:   wide = {1'b0, aluB};
         endcase
      end
   end

   assign aluResult = wide[7:0];

   ////////////////////////////////////////
   // Flags

   // Carry
   always_ff @(posedge clk)
   begin
      if (rst || init)
         aluC <= 1'b0;
      else if (srcCarry && funCarry && aluClkEn)
         aluC <= wide[8];
   end

   // All ones, on every move
   always_ff @(posedge clk)
   begin
      if (rst || init)
         aluOnes <= 1'b0;
      else if (srcMove && aluClkEn)
         aluOnes <= (aluResult == 8'hFF);
   end

endmodule

`default_nettype wire

// ==== verilog/kmcDestRegs.sv ====
////////////////////////////////////////
// KMC destination registers
// Branch register, output bus register and strobes
////////////////////////////////////////

`default_nettype none

module kmcDestRegs
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  writeEn,
   input  kmcMicroPkg::microWord cram,
   input  kmcDataPkg::dataByte   aluResult,
   output kmcDataPkg::dataByte   brg,
   output kmcDataPkg::dataByte   obus,
   output logic                  obusWr,
   output logic                  obussWr
);
   import kmcMicroPkg::*;

   srcSel src;
   dstSel dst;
   logic  doWrite;
   logic  loadBrg;
   logic  loadObus;

   // Decode
   assign src = cram[srcMsb:srcLsb];
   assign dst = cram[dstMsb:dstLsb];

   // Writes only on moves in the execute phase
   assign doWrite  = isMove(src) && writeEn;
   assign loadBrg  = doWrite && ((dst == dstBrg) || (dst == dstSpBrg));
   assign loadObus = doWrite && ((dst == dstObus) || (dst == dstObuss));

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         brg     <= '0;
         obus    <= '0;
         obusWr  <= 1'b0;
         obussWr <= 1'b0;
      end
      else
      begin
         if (loadBrg)
            brg <= aluResult;
         if (loadObus)
            obus <= aluResult;
         // Strobes line up with done
         obusWr  <= doWrite && (dst == dstObus);
         obussWr <= doWrite && (dst == dstObuss);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/kmcDatapath.sv ====
////////////////////////////////////////
// KMC data path top
// Sequencer, data mux, ALU and destination registers
////////////////////////////////////////

`default_nettype none

module kmcDatapath
(
   input  logic                  clk,
   input  logic                  rst,
   input  kmcMicroPkg::microWord cram,
   input  logic                  step,
   input  logic                  init,
   input  kmcDataPkg::dataByte   ibus,
   input  kmcDataPkg::dataByte   ibuss,
   input  kmcDataPkg::dataByte   memData,
   output kmcDataPkg::dataByte   obus,
   output logic                  obusWr,
   output logic                  obussWr,
   output kmcDataPkg::dataByte   brg,
   output logic                  aluC,
   output logic                  aluOnes,
   output logic                  done
);
   import kmcDataPkg::*;

   // Phase enables
   logic    spClkEn;
   logic    aluClkEn;
   logic    writeEn;

   // Data
   dataByte dmux;
   dataByte aluResult;

   kmcSequencer i_seq
   (
      .clk      (clk),
      .rst      (rst),
      .step     (step),
      .spClkEn  (spClkEn),
      .aluClkEn (aluClkEn),
      .writeEn  (writeEn),
      .done     (done)
   );

   kmcDataMux i_mux
   (
      .cram    (cram),
      .ibus    (ibus),
      .ibuss   (ibuss),
      .memData (memData),
      .brg     (brg),
      .dmux    (dmux)
   );

   kmcAlu i_alu
   (
      .clk       (clk),
      .rst       (rst),
      .init      (init),
      .spClkEn   (spClkEn),
      .aluClkEn  (aluClkEn),
      .cram      (cram),
      .dmux      (dmux),
      .aluResult (aluResult),
      .aluC      (aluC),
      .aluOnes   (aluOnes)
   );

   kmcDestRegs i_dest
   (
      .clk       (clk),
      .rst       (rst),
      .writeEn   (writeEn),
      .cram      (cram),
      .aluResult (aluResult),
      .brg       (brg),
      .obus      (obus),
      .obusWr    (obusWr),
      .obussWr   (obussWr)
   );

endmodule

`default_nettype wire

// ==== sim/kmcDatapath_assertions.sv ====
////////////////////////////////////////
// KMC data path assertions
// Sequencer timing and write strobe checks
////////////////////////////////////////

`default_nettype none

module kmcDatapathAssertions
(
   input logic                clk,
   input logic                rst,
   input logic                step,
   input kmcDataPkg::seqState state,
   input logic                done,
   input logic                obusWr,
   input logic                obussWr
);
   timeunit 1ns;
   timeprecision 1ps;

   import kmcDataPkg::*;

   // Single-cycle pulses
   doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done held longer than one cycle");
   obusWrOneCycle: assert property (@(posedge clk) disable iff (rst) obusWr |=> !obusWr)
      else $error("obusWr held longer than one cycle");
   obussWrOneCycle: assert property (@(posedge clk) disable iff (rst) obussWr |=> !obussWr)
      else $error("obussWr held longer than one cycle");

   // Step seen in idle, done high in the cycle after N+2
   stepToDone: assert property (@(posedge clk) disable iff (rst)
                                (step && state == seqIdle) |-> ##3 done)
      else $error("done did not follow step");

   // One output strobe at a time
   strobesExclusive: assert property (@(posedge clk) disable iff (rst) !(obusWr && obussWr))
      else $error("obusWr and obussWr high together");

endmodule

bind kmcDatapath kmcDatapathAssertions i_assertions
(
   .clk     (clk),
   .rst     (rst),
   .step    (step),
   .state   (i_seq.state),
   .done    (done),
   .obusWr  (obusWr),
   .obussWr (obussWr)
);

`default_nettype wire

// ==== sim/kmcDatapathTb.sv ====
////////////////////////////////////////
// KMC data path testbench
// Directed tests checked against a byte model
// of the scratch pad, carry, flags and brg
////////////////////////////////////////

`default_nettype none

module kmcDatapathTb;
   timeunit 1ns;
   timeprecision 1ps;

   import kmcMicroPkg::*;
   import kmcDataPkg::*;

   localparam int doneTimeout = 20;
   // Carry-changing functions
   localparam aluFun arithFuns [0:9] = '{funAdd, funAddC, funSubC, funIncA, funAPlusC,
                                         funTwoA, funTwoAC, funDecA, funSub, funSubOC};
   // Logic and selects
   localparam aluFun logicFuns [0:5] = '{funSelA, funSelB, funAOrNB, funAAndB, funAOrB,
                                         funAXorB};

   logic     clk;
   logic     rst;
   microWord cram;
   logic     step;
   logic     init;
   dataByte  ibus;
   dataByte  ibuss;
   dataByte  memData;
   dataByte  obus;
   logic     obusWr;
   logic     obussWr;
   dataByte  brg;
   logic     aluC;
   logic     aluOnes;
   logic     done;

   // Reference model state
   dataByte  spModel [0:15];
   dataByte  brgModel;
   dataByte  obusModel;
   logic     carryModel;
   logic     onesModel;
   logic     expObusWr;
   logic     expObussWr;
   int       errorCount;

   kmcDatapath i_dut
   (
      .clk     (clk),
      .rst     (rst),
      .cram    (cram),
      .step    (step),
      .init    (init),
      .ibus    (ibus),
      .ibuss   (ibuss),
      .memData (memData),
      .obus    (obus),
      .obusWr  (obusWr),
      .obussWr (obussWr),
      .brg     (brg),
      .aluC    (aluC),
      .aluOnes (aluOnes),
      .done    (done)
   );

   // 10 ns clock
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers

   function automatic microWord makeWord(srcSel src, dstSel dst, aluFun fun, spIndex addr);
      return {src, dst, 2'b00, fun, addr};
   endfunction

   // Immediate overlays function and address
   function automatic microWord makeImm(srcSel src, dstSel dst, dataByte imm);
      return {src, dst, 2'b00, imm};
   endfunction

   task automatic checkEq(input string name, input logic [7:0] actual,
                          input logic [7:0] expected);
      if (actual !== expected)
      begin
         errorCount++;
         $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Simulation failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic timedOut(input string what);
      $display("Timeout: %s", what);
      $display("Simulation failed");
      $fatal(1, "stopped on timeout");
   endtask

   // Model one microinstruction
   task automatic predictOp(input microWord word, input dataByte busVal, input dataByte memVal);
      srcSel   src;
      dstSel   dst;
      aluFun   fun;
      spIndex  addr;
      logic    move;
      logic    arith;
      int      a;
      int      b;
      int      c;
      int      full;
      dataByte res;
      src  = word[15:13];
      dst  = word[12:10];
      fun  = word[7:4];
      // Output bus destinations read location 0
      addr = (dst == dstObus || dst == dstObuss) ? 4'd0 : word[3:0];
      move = src inside {movImmed, movIbus, movMem, movBrg, movIbuss};
      a    = int'(spModel[addr]);
      c    = int'(carryModel);
      case (src)
         movImmed, jmpImmed: b = int'(word[7:0]);
         movIbus:  b = int'(busVal);
         movIbuss: b = int'(dataByte'(~busVal));
         movMem:   b = int'(memVal);
         movBrg:   b = int'(brgModel);
         default:  b = 0;
      endcase
      full  = b;
      arith = 1'b0;
      // Memory, brg and non-move sources go through the table
      if (!(src inside {movImmed, jmpImmed, movIbus, movIbuss}))
      begin
         arith = !(fun inside {funSelA, funSelB, funAOrNB, funAAndB, funAOrB, funAXorB});
         case (fun)
            funAdd:    full = a + b;
            funAddC:   full = a + b + c;
            funSubC:   full = a - b - c;
            funIncA:   full = a + 1;
            funAPlusC: full = a + c;
            funTwoA:   full = 2 * a;
            funTwoAC:  full = 2 * a + c;
            funDecA:   full = a - 1;
            funSelA:   full = a;
            funSelB:   full = b;
            funAOrNB:  full = (a | ~b) & 255;
            funAAndB:  full = a & b;
            funAOrB:   full = a | b;
            funAXorB:  full = a ^ b;
            funSub:    full = a - b;
            funSubOC:  full = a - b - 1;
         endcase
      end
      res = dataByte'(full & 255);
      if (move)
      begin
         if (dst == dstSp || dst == dstSpBrg)
            spModel[addr] = res;
         if (dst == dstBrg || dst == dstSpBrg)
            brgModel = res;
         if (dst == dstObus || dst == dstObuss)
            obusModel = res;
         onesModel = (res == 8'hFF);
         // Carry out above 255, borrow below 0
         if ((src == movMem || src == movBrg) && arith)
            carryModel = (full < 0) || (full > 255);
      end
      expObusWr  = move && (dst == dstObus);
      expObussWr = move && (dst == dstObuss);
   endtask

   // Step one microinstruction, wait for done, compare outputs
   task automatic execOp(input microWord word, input dataByte busVal, input dataByte memVal);
      int waitCycles;
      predictOp(word, busVal, memVal);
      @(posedge clk);
      cram    <= word;
      ibus    <= busVal;
      ibuss   <= ~busVal;
      memData <= memVal;
      step    <= 1'b1;
      @(posedge clk);
      step <= 1'b0;
      waitCycles = 0;
      @(negedge clk);
      while (!done && waitCycles < doneTimeout)
      begin
         waitCycles++;
         @(negedge clk);
      end
      if (!done)
         timedOut("no done pulse after a step");
      else
      begin
         checkEq("brg", brg, brgModel);
         checkEq("obus", obus, obusModel);
         checkEq("aluC", 8'(aluC), 8'(carryModel));
         checkEq("aluOnes", 8'(aluOnes), 8'(onesModel));
         checkEq("obusWr", 8'(obusWr), 8'(expObusWr));
         checkEq("obussWr", 8'(obussWr), 8'(expObussWr));
      end
   endtask

   ////////////////////////////////////////
   // Directed tests

   task automatic moveAndReadBack();
      dataByte val;
      for (int i = 0; i < 8; i++)
      begin
         val = dataByte'($urandom);
         // Even passes land at location 0
         if (i % 2 == 0)
            val[3:0] = 4'h0;
         // Low nibble of the immediate is also the address
         execOp(makeImm(movImmed, dstSp, val), 8'h00, 8'h00);
         // Address field ignored for the output bus
         execOp(makeWord(movMem, dstObus, funSelA, 4'hF), 8'h00, 8'h00);
         checkEq("obusWr", 8'(obusWr), 8'd1);
         if (i % 2 == 0)
            checkEq("obus", obus, val);
         // Status bus copy pulses its own strobe
         execOp(makeWord(movMem, dstObuss, funSelA, 4'hF), 8'h00, 8'h00);
         checkEq("obussWr", 8'(obussWr), 8'd1);
         execOp(makeWord(movMem, dstBrg, funSelA, val[3:0]), 8'h00, 8'h00);
         checkEq("brg", brg, val);
      end
   endtask

   task automatic arithFromMemory();
      spIndex  addr;
      dataByte a;
      dataByte b;
      // Two rounds so both carry values come in
      for (int n = 0; n < 20; n++)
      begin
         addr = spIndex'($urandom);
         a    = dataByte'($urandom);
         b    = dataByte'($urandom);
         execOp(makeWord(movIbus, dstSp, funSelB, addr), a, 8'h00);
         execOp(makeWord(movMem, dstBrg, arithFuns[n % 10], addr), 8'h00, b);
      end
   endtask

   task automatic carryChain();
      // FF + 01 sets the carry
      execOp(makeWord(movIbus, dstSp, funSelB, 4'd2), 8'hFF, 8'h00);
      execOp(makeWord(movMem, dstBrg, funAdd, 4'd2), 8'h00, 8'h01);
      checkEq("aluC", 8'(aluC), 8'd1);
      // FF + 10 + 1
      execOp(makeWord(movMem, dstBrg, funAddC, 4'd2), 8'h00, 8'h10);
      checkEq("brg", brg, 8'h10);
      checkEq("aluC", 8'(aluC), 8'd1);
      // ibus source, carry held
      execOp(makeWord(movIbus, dstBrg, funAdd, 4'd2), 8'h33, 8'h00);
      checkEq("aluC", 8'(aluC), 8'd1);
      // ibuss source carries the inverted byte, carry held
      execOp(makeWord(movIbuss, dstBrg, funAdd, 4'd2), 8'h5A, 8'h00);
      checkEq("brg", brg, 8'hA5);
      checkEq("aluC", 8'(aluC), 8'd1);
      // 50 - 20 - 1
      execOp(makeWord(movIbus, dstSp, funSelB, 4'd3), 8'h50, 8'h00);
      execOp(makeWord(movMem, dstBrg, funSubC, 4'd3), 8'h00, 8'h20);
      checkEq("brg", brg, 8'h2F);
      checkEq("aluC", 8'(aluC), 8'd0);
      // 50 - 60 borrows
      execOp(makeWord(movMem, dstBrg, funSubC, 4'd3), 8'h00, 8'h60);
      checkEq("brg", brg, 8'hF0);
      checkEq("aluC", 8'(aluC), 8'd1);
      // Borrow back in, 50 - 10 - 1
      execOp(makeWord(movMem, dstBrg, funSubC, 4'd3), 8'h00, 8'h10);
      checkEq("brg", brg, 8'h3F);
      checkEq("aluC", 8'(aluC), 8'd0);
   endtask

   task automatic logicFromBrg();
      spIndex  addr;
      for (int i = 0; i < 6; i++)
      begin
         addr = spIndex'($urandom);
         execOp(makeWord(movIbus, dstSp, funSelB, addr), dataByte'($urandom), 8'h00);
         execOp(makeWord(movIbus, dstBrg, funSelB, addr), dataByte'($urandom), 8'h00);
         execOp(makeWord(movBrg, dstBrg, logicFuns[i], addr), 8'h00, 8'h00);
      end
   endtask

   task automatic onesAndInit();
      execOp(makeImm(movImmed, dstNone, 8'hFF), 8'h00, 8'h00);
      checkEq("aluOnes", 8'(aluOnes), 8'd1);
      execOp(makeImm(movImmed, dstNone, 8'h7E), 8'h00, 8'h00);
      checkEq("aluOnes", 8'(aluOnes), 8'd0);
      // FF + 1 sets carry, then FF sets all ones
      execOp(makeWord(movIbus, dstSp, funSelB, 4'd4), 8'hFF, 8'h00);
      execOp(makeWord(movMem, dstNone, funIncA, 4'd4), 8'h00, 8'h00);
      execOp(makeImm(movImmed, dstNone, 8'hFF), 8'h00, 8'h00);
      checkEq("aluC", 8'(aluC), 8'd1);
      checkEq("aluOnes", 8'(aluOnes), 8'd1);
      @(posedge clk);
      init <= 1'b1;
      @(posedge clk);
      init <= 1'b0;
      @(negedge clk);
      carryModel = 1'b0;
      onesModel  = 1'b0;
      checkEq("aluC", 8'(aluC), 8'd0);
      checkEq("aluOnes", 8'(aluOnes), 8'd0);
   endtask

   task automatic ignoreSecondStep();
      microWord word;
      dataByte  a;
      int       doneCount;
      a = dataByte'($urandom);
      execOp(makeWord(movIbus, dstSp, funSelB, 4'd9), a, 8'h00);
      // Increment in place shows a second run
      word = makeWord(movMem, dstSp, funIncA, 4'd9);
      predictOp(word, 8'h00, 8'h00);
      @(posedge clk);
      cram    <= word;
      ibus    <= 8'h00;
      ibuss   <= 8'hFF;
      memData <= 8'h00;
      step    <= 1'b1;
      // Step stays high into the read phase
      @(posedge clk);
      @(posedge clk);
      step <= 1'b0;
      doneCount = 0;
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk);
         if (done)
            doneCount++;
      end
      checkEq("done count", 8'(doneCount), 8'd1);
      execOp(makeWord(movMem, dstBrg, funSelA, 4'd9), 8'h00, 8'h00);
      checkEq("brg", brg, a + 8'd1);
   endtask

   ////////////////////////////////////////
   // Main sequence

   initial
   begin
      void'($urandom(32'h17ef02ec));
      errorCount = 0;
      rst        = 1'b1;
      cram       = '0;
      step       = 1'b0;
      init       = 1'b0;
      ibus       = '0;
      ibuss      = '0;
      memData    = '0;
      brgModel   = '0;
      obusModel  = '0;
      carryModel = 1'b0;
      onesModel  = 1'b0;
      expObusWr  = 1'b0;
      expObussWr = 1'b0;
      for (int i = 0; i < 16; i++)
         spModel[i] = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      // Reset state
      @(negedge clk);
      checkEq("done", 8'(done), 8'd0);
      checkEq("obusWr", 8'(obusWr), 8'd0);
      checkEq("obussWr", 8'(obussWr), 8'd0);
      checkEq("brg", brg, 8'h00);
      checkEq("aluC", 8'(aluC), 8'd0);
      moveAndReadBack();
      arithFromMemory();
      carryChain();
      logicFromBrg();
      onesAndInit();
      ignoreSecondStep();
      if (errorCount == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/kmcMicroPkg.sv
verilog/kmcDataPkg.sv
verilog/kmcSequencer.sv
verilog/kmcDataMux.sv
verilog/kmcAlu.sv
verilog/kmcDestRegs.sv
verilog/kmcDatapath.sv
sim/kmcDatapath_assertions.sv
sim/kmcDatapathTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the KMC data path testbench with Verilator.
# A failed build or a failing run puts the fail message in sim.log.

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
   --top-module kmcDatapathTb -o kmcDatapathSim \
   && ./obj_dir/kmcDatapathSim > sim.log 2>&1 \
   || echo "Simulation failed" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
